/* flist.f */
+incdir+include
hw/wall_pkg.sv
hw/room_select.sv
hw/pixel_tiler.sv
hw/tile_classifier.sv
hw/wall_map.sv
verification/wall_map_properties.sv
verification/wall_map_checker.sv
verification/wall_map_tb.sv

/* hw/pixel_tiler.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_tiler (
	input logic clk,
	input logic rst_n,
	input logic pixel_valid,
	input wall_pkg::pixel_t pixel,
	input wall_pkg::room_t active_room,
	input logic room_enabled,
	output logic tile_valid,
	output wall_pkg::tile_pos_t tile_pos,
	output wall_pkg::room_t tile_room,
	output logic tile_room_enabled
);

	import wall_pkg::*;

	coord_t col;
	coord_t row;
	coord_t col_off;
	coord_t row_off;
	logic on_screen;

	// constant divisor, so no real divider is built
	always_comb
	begin
		col = pixel.x / TILE_DIM;
		row = pixel.y / TILE_DIM;
		col_off = pixel.x % TILE_DIM;
		row_off = pixel.y % TILE_DIM;
		on_screen = (col < SCREEN_TILES_X) && (row < SCREEN_TILES_Y);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tile_valid <= 1'b0;
			tile_room_enabled <= 1'b0;
		end
		else
		begin
			tile_valid <= pixel_valid;
			// off-screen pixels would alias onto real tiles
			tile_room_enabled <= room_enabled && on_screen;
		end
	end

	always_ff @(posedge clk)
	begin
		tile_pos.tile_x <= col[4:0];
		tile_pos.tile_y <= row[4:0];
		tile_pos.off_x <= col_off[4:0];
		tile_pos.off_y <= row_off[4:0];
		// room rides along with its pixel
		tile_room <= active_room;
	end

endmodule

`default_nettype wire

/* hw/room_select.sv */
`timescale 1ns/100ps
`default_nettype none

module room_select (
	input logic clk,
	input logic rst_n,
	input logic frame_start,
	input wall_pkg::room_t room_num,
	output wall_pkg::room_t active_room,
	output logic room_enabled
);

	import wall_pkg::*;

	// room of the frame being drawn
	room_t held_room;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			held_room <= '0;
		end
		else if (frame_start)
		begin
			held_room <= room_num;
		end
	end

	always_comb
	begin
		// first pixel of a frame already sees the new room
		active_room = frame_start ? room_num : held_room;
		// rooms past the table draw nothing
		room_enabled = (active_room < NUM_ROOMS);
	end

endmodule

`default_nettype wire

/* hw/tile_classifier.sv */
`timescale 1ns/100ps
`default_nettype none

module tile_classifier (
	input logic clk,
	input logic rst_n,
	input logic tile_valid,
	input wall_pkg::tile_pos_t tile_pos,
	input wall_pkg::room_t tile_room,
	input logic tile_room_enabled,
	output logic wall_valid,
	output wall_pkg::wall_px_t wall_px
);

	import wall_pkg::*;

	`include "room_layouts.svh"

	logic [$clog2(NUM_ROOMS)-1:0] room_sel;
	rect_idx_t first_rect;
	// one past the last rectangle of the room
	rect_idx_t end_rect;
	logic hit;
	logic hit_brick;
	wall_px_t px_next;

	// spans are summed in 7 bits, some run past tile 31
	function automatic logic covers(wall_rect_t rect, tile_pos_t pos);
		logic [6:0] x_end;
		logic [6:0] y_end;
		x_end = 7'(rect.x0) + 7'(rect.width);
		y_end = 7'(rect.y0) + 7'(rect.height);
		return (pos.tile_x >= rect.x0) && (7'(pos.tile_x) < x_end)
			&& (pos.tile_y >= rect.y0) && (7'(pos.tile_y) < y_end);
	endfunction

	always_comb
	begin
		room_sel = tile_room[$clog2(NUM_ROOMS)-1:0];
		first_rect = ROOM_BASE[room_sel];
		end_rect = first_rect + ROOM_COUNT[room_sel];
	end

	// priority search, same order as the layout listing
	always_comb
	begin
		hit = 1'b0;
		hit_brick = 1'b0;
		for (int i = 0; i < NUM_RECTS; i++)
		begin
			if (!hit && (rect_idx_t'(i) >= first_rect) && (rect_idx_t'(i) < end_rect)
				&& covers(ROOM_RECTS[i], tile_pos))
			begin
				hit = 1'b1;
				hit_brick = ROOM_RECTS[i].brick;
			end
		end
	end

	always_comb
	begin
		px_next = '0;
		if (hit && tile_room_enabled)
		begin
			px_next.is_wall = 1'b1;
			px_next.is_brick = hit_brick;
			// row-major texel inside the 20x20 tile
			px_next.texel_addr = texel_addr_t'(tile_pos.off_x)
				+ texel_addr_t'(tile_pos.off_y) * texel_addr_t'(TILE_DIM);
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wall_valid <= 1'b0;
			wall_px <= '0;
		end
		else
		begin
			wall_valid <= tile_valid;
			// zero between pixels
			wall_px <= tile_valid ? px_next : '0;
		end
	end

endmodule

`default_nettype wire

/* hw/wall_map.sv */
`timescale 1ns/100ps
`default_nettype none

module wall_map (
	input logic clk,
	input logic rst_n,
	input logic pixel_valid,
	input wall_pkg::pixel_t pixel,
	input logic frame_start,
	input wall_pkg::room_t room_num,
	output logic wall_valid,
	output wall_pkg::wall_px_t wall_px
);

	import wall_pkg::*;

	room_t active_room;
	logic room_enabled;
	logic tile_valid;
	tile_pos_t tile_pos;
	room_t tile_room;
	logic tile_room_enabled;

	room_select room_select_inst (
		.clk(clk),
		.rst_n(rst_n),
		.frame_start(frame_start),
		.room_num(room_num),
		.active_room(active_room),
		.room_enabled(room_enabled)
	);

	// stage 1
	pixel_tiler pixel_tiler_inst (
		.clk(clk),
		.rst_n(rst_n),
		.pixel_valid(pixel_valid),
		.pixel(pixel),
		.active_room(active_room),
		.room_enabled(room_enabled),
		.tile_valid(tile_valid),
		.tile_pos(tile_pos),
		.tile_room(tile_room),
		.tile_room_enabled(tile_room_enabled)
	);

	// stage 2
	tile_classifier tile_classifier_inst (
		.clk(clk),
		.rst_n(rst_n),
		.tile_valid(tile_valid),
		.tile_pos(tile_pos),
		.tile_room(tile_room),
		.tile_room_enabled(tile_room_enabled),
		.wall_valid(wall_valid),
		.wall_px(wall_px)
	);

endmodule

`default_nettype wire

/* hw/wall_pkg.sv */
`default_nettype none

package wall_pkg;

	typedef logic [9:0] coord_t;
	typedef logic [4:0] tile_idx_t;
	// offset inside a tile, 0 to 19
	typedef logic [4:0] tile_off_t;
	typedef logic [2:0] room_t;
	typedef logic [8:0] texel_addr_t;

	// tile edge in pixels
	localparam coord_t TILE_DIM = 10'd20;

	// visible screen in tiles, 640x480
	localparam coord_t SCREEN_TILES_X = 10'd32;
	localparam coord_t SCREEN_TILES_Y = 10'd24;

	// start screen plus three levels
	localparam room_t NUM_ROOMS = 3'd4;

	// has to track the table in room_layouts.svh
	localparam int NUM_RECTS = 69;

	typedef logic [$clog2(NUM_RECTS + 1)-1:0] rect_idx_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pixel_t;

	typedef struct packed {
		tile_idx_t tile_x;
		tile_idx_t tile_y;
		tile_off_t off_x;
		tile_off_t off_y;
	} tile_pos_t;

	// rectangle of wall tiles, all in tile units
	typedef struct packed {
		tile_idx_t x0;
		tile_idx_t y0;
		logic [5:0] width;
		logic [5:0] height;
		logic brick;
	} wall_rect_t;

	typedef struct packed {
		logic is_wall;
		logic is_brick;
		texel_addr_t texel_addr;
	} wall_px_t;

endpackage

`default_nettype wire

/* include/room_layouts.svh */
`ifndef ROOM_LAYOUTS_SVH
`define ROOM_LAYOUTS_SVH

// {x0, y0, width, height, brick} in tiles
// each room is searched top to bottom, first hit wins
localparam wall_rect_t ROOM_RECTS [NUM_RECTS] = '{
	// room 0, start screen: floor and border
	'{5'd0, 5'd23, 6'd32, 6'd1, 1'b0},
	'{5'd0, 5'd22, 6'd32, 6'd1, 1'b0},
	'{5'd0, 5'd0, 6'd32, 6'd1, 1'b0},
	'{5'd31, 5'd0, 6'd1, 6'd18, 1'b0},
	'{5'd0, 5'd0, 6'd1, 6'd18, 1'b0},

	// room 1, platforms first
	'{5'd4, 5'd21, 6'd4, 6'd1, 1'b0},
	'{5'd5, 5'd20, 6'd3, 6'd1, 1'b0},
	'{5'd6, 5'd19, 6'd2, 6'd1, 1'b0},
	'{5'd12, 5'd21, 6'd4, 6'd1, 1'b0},
	'{5'd12, 5'd20, 6'd3, 6'd1, 1'b0},
	'{5'd12, 5'd19, 6'd2, 6'd1, 1'b0},
	'{5'd11, 5'd15, 6'd4, 6'd1, 1'b1},
	'{5'd10, 5'd11, 6'd4, 6'd1, 1'b1},
	'{5'd5, 5'd13, 6'd4, 6'd1, 1'b1},
	'{5'd1, 5'd9, 6'd4, 6'd1, 1'b0},
	'{5'd2, 5'd6, 6'd1, 6'd1, 1'b0},
	'{5'd18, 5'd13, 6'd4, 6'd1, 1'b1},
	'{5'd0, 5'd0, 6'd32, 6'd1, 1'b0},
	'{5'd31, 5'd0, 6'd1, 6'd18, 1'b0},
	'{5'd0, 5'd0, 6'd1, 6'd18, 1'b0},
	'{5'd20, 5'd21, 6'd1, 6'd1, 1'b0},
	'{5'd26, 5'd21, 6'd2, 6'd2, 1'b0},
	'{5'd27, 5'd20, 6'd1, 6'd1, 1'b0},
	'{5'd0, 5'd23, 6'd8, 6'd1, 1'b0},
	'{5'd0, 5'd22, 6'd8, 6'd1, 1'b0},
	// floor after the pit, runs past the right edge
	'{5'd12, 5'd23, 6'd22, 6'd1, 1'b0},
	'{5'd12, 5'd22, 6'd22, 6'd1, 1'b0},

	// room 2
	'{5'd5, 5'd17, 6'd6, 6'd1, 1'b1},
	'{5'd8, 5'd15, 6'd1, 6'd1, 1'b1},
	'{5'd10, 5'd12, 6'd3, 6'd1, 1'b1},
	'{5'd3, 5'd12, 6'd4, 6'd1, 1'b1},
	'{5'd3, 5'd9, 6'd2, 6'd1, 1'b1},
	'{5'd12, 5'd9, 6'd8, 6'd1, 1'b1},
	'{5'd22, 5'd1, 6'd1, 6'd12, 1'b0},
	'{5'd3, 5'd21, 6'd1, 6'd1, 1'b0},
	'{5'd0, 5'd0, 6'd32, 6'd1, 1'b0},
	'{5'd31, 5'd0, 6'd1, 6'd18, 1'b0},
	'{5'd0, 5'd0, 6'd1, 6'd18, 1'b0},
	'{5'd0, 5'd23, 6'd8, 6'd1, 1'b0},
	'{5'd0, 5'd22, 6'd8, 6'd1, 1'b0},
	// floor islands between holes
	'{5'd15, 5'd23, 6'd2, 6'd1, 1'b0},
	'{5'd15, 5'd22, 6'd2, 6'd1, 1'b0},
	'{5'd20, 5'd23, 6'd2, 6'd1, 1'b0},
	'{5'd20, 5'd22, 6'd2, 6'd1, 1'b0},
	'{5'd25, 5'd23, 6'd7, 6'd1, 1'b0},
	'{5'd25, 5'd22, 6'd7, 6'd1, 1'b0},

	// room 3, ceiling with an exit gap
	'{5'd0, 5'd0, 6'd23, 6'd1, 1'b0},
	'{5'd26, 5'd0, 6'd7, 6'd1, 1'b0},
	'{5'd31, 5'd5, 6'd1, 6'd19, 1'b0},
	'{5'd0, 5'd0, 6'd1, 6'd18, 1'b0},
	'{5'd0, 5'd23, 6'd5, 6'd1, 1'b0},
	'{5'd0, 5'd22, 6'd5, 6'd1, 1'b0},
	// pillar pairs, each split by a gap
	'{5'd7, 5'd19, 6'd1, 6'd6, 1'b0},
	'{5'd8, 5'd19, 6'd1, 6'd6, 1'b0},
	'{5'd7, 5'd1, 6'd1, 6'd15, 1'b0},
	'{5'd8, 5'd1, 6'd1, 6'd15, 1'b0},
	'{5'd13, 5'd18, 6'd1, 6'd7, 1'b0},
	'{5'd13, 5'd1, 6'd1, 6'd14, 1'b0},
	'{5'd14, 5'd18, 6'd1, 6'd7, 1'b0},
	'{5'd14, 5'd1, 6'd1, 6'd14, 1'b0},
	'{5'd18, 5'd19, 6'd1, 6'd10, 1'b0},
	'{5'd18, 5'd1, 6'd1, 6'd11, 1'b0},
	'{5'd22, 5'd16, 6'd1, 6'd9, 1'b0},
	'{5'd22, 5'd1, 6'd1, 6'd12, 1'b0},
	// stepping bricks up to the exit
	'{5'd24, 5'd14, 6'd1, 6'd1, 1'b1},
	'{5'd28, 5'd13, 6'd1, 6'd1, 1'b1},
	'{5'd24, 5'd9, 6'd1, 6'd1, 1'b1},
	'{5'd28, 5'd7, 6'd1, 6'd1, 1'b1},
	'{5'd29, 5'd5, 6'd2, 6'd1, 1'b0}
};

// slice of ROOM_RECTS owned by each room
localparam rect_idx_t ROOM_BASE [NUM_ROOMS] = '{7'd0, 7'd5, 7'd27, 7'd46};
localparam rect_idx_t ROOM_COUNT [NUM_ROOMS] = '{7'd5, 7'd22, 7'd19, 7'd23};

`endif

/* run_sim.sh */
#!/bin/sh
# build and run the wall_map testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f flist.f \
	--top-module wall_map_tb \
	-Mdir obj_dir -o wall_map_sim

# keep running past assertion errors so the testbench prints its verdict
status=0
./obj_dir/wall_map_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
	echo "run_sim: testbench reported failure"
	exit 1
fi

if [ "$status" -ne 0 ] || ! grep -q "Verification passed" sim.log; then
	echo "run_sim: simulation ended abnormally"
	exit 1
fi

echo "run_sim: done"

/* verification/wall_map_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module wall_map_checker (
	input logic clk,
	input logic rst_n,
	input logic pixel_valid,
	input wall_pkg::pixel_t pixel,
	input logic exp_wall,
	input logic exp_brick,
	input logic wall_valid,
	input wall_pkg::wall_px_t wall_px,
	output int value_errors,
	output int protocol_errors,
	output int pending
);

	import wall_pkg::*;

	typedef struct packed {
		coord_t x;
		coord_t y;
		logic wall;
		logic brick;
		int cycle;
	} expect_t;

	expect_t expected_q [$];
	int cycle_count = 0;

	initial
	begin
		value_errors = 0;
		protocol_errors = 0;
	end

	assign pending = expected_q.size();

	// row-major position inside a 20x20 tile
	function automatic int texel_of(coord_t x, coord_t y);
		return (int'(x) % int'(TILE_DIM)) + (int'(y) % int'(TILE_DIM)) * int'(TILE_DIM);
	endfunction

	task automatic report_mismatch(string field, int got, int want, expect_t e);
		value_errors++;
		$display("FAILED at %0t: %s is %0d, expected %0d, pixel (%0d,%0d)",
			$time, field, got, want, e.x, e.y);
	endtask

	task automatic check_result();
		expect_t e;
		int want_addr;
		int latency;
		if (expected_q.size() == 0)
		begin
			protocol_errors++;
			$display("unexpected wall_valid at %0t with no pixel outstanding", $time);
		end
		else
		begin
			e = expected_q.pop_front();
			// counted up to the rising edge that samples this result
			latency = cycle_count + 1 - e.cycle;
			if (latency != 2)
			begin
				protocol_errors++;
				$display("result for pixel (%0d,%0d) came %0d cycles after its input",
					e.x, e.y, latency);
			end
			want_addr = e.wall ? texel_of(e.x, e.y) : 0;
			if (wall_px.is_wall !== e.wall)
				report_mismatch("is_wall", int'(wall_px.is_wall), int'(e.wall), e);
			if (wall_px.is_brick !== e.brick)
				report_mismatch("is_brick", int'(wall_px.is_brick), int'(e.brick), e);
			if (int'(wall_px.texel_addr) != want_addr)
				report_mismatch("texel_addr", int'(wall_px.texel_addr), want_addr, e);
		end
	endtask

	// inputs settle on the falling edge, so take them on the rising one
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (rst_n && pixel_valid)
		begin
			expected_q.push_back('{pixel.x, pixel.y, exp_wall, exp_brick, cycle_count});
		end
	end

	// outputs are stable half a cycle after the edge
	always @(negedge clk)
	begin
		if (rst_n && wall_valid)
		begin
			check_result();
		end
	end

endmodule

`default_nettype wire

/* verification/wall_map_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module wall_map_properties (
	input logic clk,
	input logic rst_n,
	input logic pixel_valid,
	input logic wall_valid,
	input wall_pkg::wall_px_t wall_px
);

	// read by the testbench at the end of the run
	int assert_fails = 0;

	// two register stages between a pixel and its result
	valid_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
		wall_valid == $past(pixel_valid, 2))
		else begin
			$error("wall_valid does not follow pixel_valid by two cycles");
			assert_fails++;
		end

	brick_is_wall_a: assert property (@(posedge clk) disable iff (!rst_n)
		wall_px.is_brick |-> wall_px.is_wall)
		else begin
			$error("is_brick set on a pixel that is not a wall");
			assert_fails++;
		end

	empty_is_blank_a: assert property (@(posedge clk) disable iff (!rst_n)
		!wall_px.is_wall |-> (wall_px.texel_addr == '0) && !wall_px.is_brick)
		else begin
			$error("non-wall pixel carries an address or a brick flag");
			assert_fails++;
		end

	reset_quiet_a: assert property (@(posedge clk) !rst_n |-> !wall_valid)
		else begin
			$error("wall_valid high while in reset");
			assert_fails++;
		end

endmodule

bind wall_map wall_map_properties wall_map_props (
	.clk(clk),
	.rst_n(rst_n),
	.pixel_valid(pixel_valid),
	.wall_valid(wall_valid),
	.wall_px(wall_px)
);

`default_nettype wire

/* verification/wall_map_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module wall_map_tb;

	import wall_pkg::*;

	typedef struct packed {
		logic frame_start;
		room_t room;
		coord_t x;
		coord_t y;
		logic wall;
		logic brick;
		logic [1:0] gap;
	} stim_row_t;

	localparam int NUM_ROWS = 28;
	localparam int CYCLE_LIMIT = (NUM_ROWS + 20) * 4;

	// frame_start, room, x, y, wall, brick, idle cycles after the row
	localparam stim_row_t STIM [NUM_ROWS] = '{
		// room 0 floor, border, open space and tile corners
		'{1'b1, 3'd0, 10'd300, 10'd450, 1'b1, 1'b0, 2'd0},
		'{1'b0, 3'd0, 10'd5, 10'd100, 1'b1, 1'b0, 2'd0},
		'{1'b0, 3'd0, 10'd300, 10'd200, 1'b0, 1'b0, 2'd2},
		'{1'b0, 3'd0, 10'd0, 10'd0, 1'b1, 1'b0, 2'd0},
		'{1'b0, 3'd0, 10'd639, 10'd0, 1'b1, 1'b0, 2'd0},
		'{1'b0, 3'd0, 10'd619, 10'd479, 1'b1, 1'b0, 2'd0},
		'{1'b0, 3'd0, 10'd20, 10'd459, 1'b1, 1'b0, 2'd1},
		// room 1
		'{1'b1, 3'd1, 10'd110, 10'd265, 1'b1, 1'b1, 2'd0},
		'{1'b0, 3'd1, 10'd30, 10'd185, 1'b1, 1'b0, 2'd0},
		'{1'b0, 3'd1, 10'd619, 10'd479, 1'b1, 1'b0, 2'd0},
		'{1'b0, 3'd1, 10'd300, 10'd200, 1'b0, 1'b0, 2'd3},
		// room 2
		'{1'b1, 3'd2, 10'd165, 10'd305, 1'b1, 1'b1, 2'd0},
		'{1'b0, 3'd2, 10'd179, 10'd319, 1'b1, 1'b1, 2'd0},
		'{1'b0, 3'd2, 10'd460, 10'd300, 1'b0, 1'b0, 2'd1},
		// room 3, the exit gap in the ceiling is open
		'{1'b1, 3'd3, 10'd485, 10'd285, 1'b1, 1'b1, 2'd0},
		'{1'b0, 3'd3, 10'd145, 10'd30, 1'b1, 1'b0, 2'd0},
		'{1'b0, 3'd3, 10'd480, 10'd0, 1'b0, 1'b0, 2'd0},
		// room 3 stays until a strobe, tile 8,15 is a pillar there
		'{1'b0, 3'd0, 10'd165, 10'd305, 1'b1, 1'b0, 2'd1},
		'{1'b1, 3'd0, 10'd165, 10'd305, 1'b0, 1'b0, 2'd0},
		'{1'b0, 3'd2, 10'd165, 10'd305, 1'b0, 1'b0, 2'd0},
		'{1'b1, 3'd2, 10'd165, 10'd305, 1'b1, 1'b1, 2'd2},
		// rooms without a layout
		'{1'b1, 3'd5, 10'd5, 10'd100, 1'b0, 1'b0, 2'd0},
		'{1'b0, 3'd5, 10'd300, 10'd450, 1'b0, 1'b0, 2'd0},
		'{1'b0, 3'd7, 10'd0, 10'd0, 1'b0, 1'b0, 2'd1},
		'{1'b1, 3'd7, 10'd619, 10'd479, 1'b0, 1'b0, 2'd0},
		'{1'b0, 3'd7, 10'd639, 10'd0, 1'b0, 1'b0, 2'd1},
		'{1'b1, 3'd0, 10'd5, 10'd100, 1'b1, 1'b0, 2'd0},
		'{1'b0, 3'd0, 10'd300, 10'd450, 1'b1, 1'b0, 2'd0}
	};

	logic clk;
	logic rst_n;
	logic pixel_valid;
	pixel_t pixel;
	logic frame_start;
	room_t room_num;
	logic wall_valid;
	wall_px_t wall_px;
	logic exp_wall;
	logic exp_brick;
	int value_errors;
	int protocol_errors;
	int pending;
	int cycles = 0;

	wall_map wall_map_inst (
		.clk(clk),
		.rst_n(rst_n),
		.pixel_valid(pixel_valid),
		.pixel(pixel),
		.frame_start(frame_start),
		.room_num(room_num),
		.wall_valid(wall_valid),
		.wall_px(wall_px)
	);

	wall_map_checker wall_map_checker_inst (
		.clk(clk),
		.rst_n(rst_n),
		.pixel_valid(pixel_valid),
		.pixel(pixel),
		.exp_wall(exp_wall),
		.exp_brick(exp_brick),
		.wall_valid(wall_valid),
		.wall_px(wall_px),
		.value_errors(value_errors),
		.protocol_errors(protocol_errors),
		.pending(pending)
	);

	always #10 clk = ~clk;

	task automatic drive_row(stim_row_t row);
		pixel_valid = 1'b1;
		pixel.x = row.x;
		pixel.y = row.y;
		frame_start = row.frame_start;
		room_num = row.room;
		exp_wall = row.wall;
		exp_brick = row.brick;
	endtask

	// room_num is left alone so a change can sit without a strobe
	task automatic drive_idle();
		pixel_valid = 1'b0;
		frame_start = 1'b0;
		exp_wall = 1'b0;
		exp_brick = 1'b0;
	endtask

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles, %0d results still missing", cycles, pending);
			$display("Verification failed");
			$finish;
		end
	end

	initial
	begin
		int asserts;
		int total;
		clk = 1'b0;
		rst_n = 1'b0;
		pixel_valid = 1'b0;
		pixel = '0;
		frame_start = 1'b0;
		room_num = '0;
		exp_wall = 1'b0;
		exp_brick = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			@(negedge clk);
			drive_row(STIM[i]);
			for (int g = 0; g < int'(STIM[i].gap); g++)
			begin
				@(negedge clk);
				drive_idle();
			end
		end
		@(negedge clk);
		drive_idle();
		while (pending != 0)
			@(negedge clk);
		// a few quiet cycles to catch stray results
		repeat (3) @(negedge clk);
		asserts = wall_map_inst.wall_map_props.assert_fails;
		total = value_errors + protocol_errors + asserts;
		$display("errors: %0d value, %0d protocol, %0d assertion",
			value_errors, protocol_errors, asserts);
		if (total == 0)
		begin
			$display("Verification passed");
		end
		else
		begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
